/* rtl/rv_pkg.sv */
package rv_pkg;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_LOAD} wb_sel_e;

  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      alu_src_imm;    // Operand B from imm
    logic      alu_src_pc;     // Operand A from pc
    br_op_e    br_op;
    wb_sel_e   wb_sel;
    logic      rf_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_size_e mem_size;
    logic      load_unsigned;
    logic      ebreak;
    logic      illegal;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
  } ctrl_t;

  typedef struct packed {
    logic        ren;
    logic        wen;
    logic [31:0] addr;         // Word aligned
    logic [3:0]  wmask;
    logic [31:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        rd_wen;
    logic [4:0]  rd;
    logic [31:0] rd_wdata;
    logic [31:0] next_pc;
  } retire_t;

endpackage

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]   insn,
  output rv_pkg::ctrl_t ctrl,
  output logic [31:0]   imm
);

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'd1: alu_sel = rv_pkg::ALU_SLL;
      3'd2: alu_sel = rv_pkg::ALU_SLT;
      3'd3: alu_sel = rv_pkg::ALU_SLTU;
      3'd4: alu_sel = rv_pkg::ALU_XOR;
      3'd5: alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'd6: alu_sel = rv_pkg::ALU_OR;
      default: alu_sel = rv_pkg::ALU_AND;
    endcase
  endfunction

  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign imm_i  = {{20{insn[31]}}, insn[31:20]};
  assign imm_s  = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b  = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u  = {insn[31:12], 12'd0};
  assign imm_j  = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    ctrl     = '0;
    ctrl.rs1 = insn[19:15];
    ctrl.rs2 = insn[24:20];
    ctrl.rd  = insn[11:7];
    imm      = 32'd0;
    case (insn[6:0])
      rv_pkg::OP_LUI: begin
        ctrl.alu_op      = rv_pkg::ALU_PASS_B;
        ctrl.alu_src_imm = 1'b1;
        ctrl.rf_wen      = 1'b1;
        imm              = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        ctrl.alu_src_pc  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.rf_wen      = 1'b1;
        imm              = imm_u;
      end
      rv_pkg::OP_JAL: begin
        ctrl.br_op  = rv_pkg::BR_JAL;
        ctrl.wb_sel = rv_pkg::WB_PC4;
        ctrl.rf_wen = 1'b1;
        imm         = imm_j;
      end
      rv_pkg::OP_JALR: begin
        ctrl.br_op   = rv_pkg::BR_JALR;
        ctrl.wb_sel  = rv_pkg::WB_PC4;
        ctrl.rf_wen  = 1'b1;
        ctrl.illegal = funct3 != 3'd0;
        imm          = imm_i;
      end
      rv_pkg::OP_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'd0: ctrl.br_op = rv_pkg::BR_EQ;
          3'd1: ctrl.br_op = rv_pkg::BR_NE;
          3'd4: ctrl.br_op = rv_pkg::BR_LT;
          3'd5: ctrl.br_op = rv_pkg::BR_GE;
          3'd6: ctrl.br_op = rv_pkg::BR_LTU;
          3'd7: ctrl.br_op = rv_pkg::BR_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      rv_pkg::OP_LOAD: begin
        ctrl.wb_sel        = rv_pkg::WB_LOAD;
        ctrl.rf_wen        = 1'b1;
        ctrl.mem_ren       = 1'b1;
        ctrl.mem_size      = rv_pkg::mem_size_e'(funct3[1:0]);
        ctrl.load_unsigned = funct3[2];
        ctrl.illegal       = funct3[1:0] == 2'b11 || funct3 == 3'b110;
        imm                = imm_i;
      end
      rv_pkg::OP_STORE: begin
        ctrl.mem_wen  = 1'b1;
        ctrl.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
        ctrl.illegal  = funct3[2] || funct3[1:0] == 2'b11;
        imm           = imm_s;
      end
      rv_pkg::OP_IMM: begin
        ctrl.alu_op      = alu_sel(funct3, funct3 == 3'd5 && funct7[5]);
        ctrl.alu_src_imm = 1'b1;
        ctrl.rf_wen      = 1'b1;
        ctrl.illegal     = (funct3 == 3'd1 && funct7 != 7'd0) ||
                           (funct3 == 3'd5 && {funct7[6], funct7[4:0]} != 6'd0);
        imm              = imm_i;
      end
      rv_pkg::OP_REG: begin
        ctrl.alu_op  = alu_sel(funct3, funct7[5]);
        ctrl.rf_wen  = 1'b1;
        ctrl.illegal = {funct7[6], funct7[4:0]} != 6'd0 ||
                       (funct7[5] && funct3 != 3'd0 && funct3 != 3'd5);
      end
      rv_pkg::OP_SYSTEM: begin
        ctrl.ebreak  = insn == 32'h0010_0073;
        ctrl.illegal = !ctrl.ebreak;  // No CSRs or ECALL
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin  // Falls through as a no-op
      ctrl.br_op   = rv_pkg::BR_NONE;
      ctrl.rf_wen  = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.mem_wen = 1'b0;
    end
  end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  waddr,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [31:1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  // Written value visible on the next read
  write_read_back: assert property (@(posedge clk)
    wen && waddr != 5'd0 |=> rs1 != $past(waddr) || rdata1 == $past(wdata))
    else $error("x%0d read back %h", rs1, rdata1);

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [31:0]     result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    result = a + b;
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_SLL:    result = a << shamt;
      rv_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU:   result = {31'd0, a < b};
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_SRL:    result = a >> shamt;
      rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_AND:    result = a & b;
      rv_pkg::ALU_PASS_B: result = b;  // LUI
      default:            result = 32'd0;
    endcase
  end

endmodule

/* rtl/rv_pc_unit.sv */
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           halt,
  input  rv_pkg::br_op_e br_op,
  input  logic [31:0]    rs1_val,
  input  logic [31:0]    rs2_val,
  input  logic [31:0]    imm,
  output logic [31:0]    pc,
  output logic [31:0]    pc_plus4,
  output logic [31:0]    next_pc
);

  logic taken;

  always_comb begin
    case (br_op)
      rv_pkg::BR_EQ:  taken = rs1_val == rs2_val;
      rv_pkg::BR_NE:  taken = rs1_val != rs2_val;
      rv_pkg::BR_LT:  taken = $signed(rs1_val) < $signed(rs2_val);
      rv_pkg::BR_GE:  taken = $signed(rs1_val) >= $signed(rs2_val);
      rv_pkg::BR_LTU: taken = rs1_val < rs2_val;
      rv_pkg::BR_GEU: taken = rs1_val >= rs2_val;
      rv_pkg::BR_JAL: taken = 1'b1;
      default:        taken = 1'b0;  // JALR handled below
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (br_op == rv_pkg::BR_JALR) begin
      next_pc = (rs1_val + imm) & ~32'd1;
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc misaligned %h", pc);

endmodule

/* rtl/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::ctrl_t     ctrl,
  input  logic              halt,
  input  logic [31:0]       rs1_val,
  input  logic [31:0]       rs2_val,
  input  logic [31:0]       imm,
  input  logic [31:0]       dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output logic [31:0]       load_data
);

  logic [31:0] addr;
  logic [31:0] rd_shift;   // Addressed byte moved to lane 0
  logic [31:0] lane_data;
  logic [3:0]  size_mask;

  assign addr     = rs1_val + imm;
  assign rd_shift = dmem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      rv_pkg::SIZE_BYTE: begin
        size_mask = 4'b0001;
        lane_data = {4{rs2_val[7:0]}};
        load_data = ctrl.load_unsigned ? {24'd0, rd_shift[7:0]} :
                                         {{24{rd_shift[7]}}, rd_shift[7:0]};
      end
      rv_pkg::SIZE_HALF: begin
        size_mask = 4'b0011;
        lane_data = {2{rs2_val[15:0]}};
        load_data = ctrl.load_unsigned ? {16'd0, rd_shift[15:0]} :
                                         {{16{rd_shift[15]}}, rd_shift[15:0]};
      end
      default: begin
        size_mask = 4'b1111;
        lane_data = rs2_val;
        load_data = dmem_rdata;
      end
    endcase
    dmem_req.ren   = ctrl.mem_ren & ~halt;
    dmem_req.wen   = ctrl.mem_wen & ~halt;
    dmem_req.addr  = {addr[31:2], 2'b00};
    dmem_req.wmask = dmem_req.wen ? size_mask << addr[1:0] : 4'b0000;
    dmem_req.wdata = lane_data;
    if (dmem_req.wen) begin
      assert ($countones(dmem_req.wmask) inside {1, 2, 4})
        else $error("store mask %b", dmem_req.wmask);
    end
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              rst,
  output logic [31:0]       imem_addr,
  input  logic [31:0]       imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  logic [31:0]       dmem_rdata,
  output logic              halt,
  output rv_pkg::retire_t   retire
);

  rv_pkg::ctrl_t ctrl;
  logic [31:0]   imm, rs1_val, rs2_val;
  logic [31:0]   alu_a, alu_b, alu_result, load_data;
  logic [31:0]   pc, pc_plus4, next_pc, rf_wdata;
  logic          rf_wen;

  rv_decoder u_decoder (.insn(imem_data), .ctrl(ctrl), .imm(imm));

  assign rf_wen = ctrl.rf_wen & ~halt;

  rv_regfile u_regfile (
    .clk(clk), .rs1(ctrl.rs1), .rs2(ctrl.rs2), .waddr(ctrl.rd),
    .wen(rf_wen), .wdata(rf_wdata), .rdata1(rs1_val), .rdata2(rs2_val)
  );

  assign alu_a = ctrl.alu_src_pc ? pc : rs1_val;   // AUIPC
  assign alu_b = ctrl.alu_src_imm ? imm : rs2_val;

  rv_alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  rv_pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
    .clk(clk), .rst(rst), .halt(halt), .br_op(ctrl.br_op),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
    .pc(pc), .pc_plus4(pc_plus4), .next_pc(next_pc)
  );

  rv_lsu u_lsu (
    .ctrl(ctrl), .halt(halt), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
    .dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .load_data(load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_PC4:  rf_wdata = pc_plus4;
      rv_pkg::WB_LOAD: rf_wdata = load_data;
      default:         rf_wdata = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (ctrl.ebreak) begin
      halt <= 1'b1;  // Sticky until reset
    end
  end

  assign imem_addr = pc;

  always_comb begin
    retire.valid    = ~halt;
    retire.pc       = pc;
    retire.insn     = imem_data;
    retire.rd_wen   = rf_wen;
    retire.rd       = ctrl.rd;
    retire.rd_wdata = rf_wdata;
    retire.next_pc  = next_pc;
  end

  // Fetch address must not move once stopped
  halt_freezes_pc: assert property (@(posedge clk) disable iff (rst)
    halt |=> $stable(imem_addr))
    else $error("pc moved after halt");

endmodule

/* include/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam logic [31:0] IMEM_BASE   = 32'h8000_0000;
localparam logic [31:0] DMEM_BASE   = 32'h8000_4000;  // Indexed by addr[11:2]
localparam logic [31:0] INSN_EBREAK = 32'h0010_0073;

logic [31:0] ref_rf [32];
logic [31:0] ref_dmem [1024];
logic [31:0] ref_pc;
logic        ref_halted;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
endfunction

// Shifts carry funct7 in imm[11:5]
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input rv_pkg::opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input rv_pkg::opcode_e op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
endfunction

function automatic void ref_reset();
  foreach (ref_rf[i]) begin
    ref_rf[i] = 32'd0;
  end
  ref_pc     = IMEM_BASE;
  ref_halted = 1'b0;
endfunction

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// rd_wdata is defined only with rd_wen, addr and wdata only with a strobe
function automatic void ref_step(input logic [31:0] insn, output rv_pkg::retire_t r,
                                 output rv_pkg::dmem_req_t m);
  logic [31:0] a, b, ii, is, res, ea, word;
  logic        wr, taken;
  a     = ref_rf[insn[19:15]];
  b     = ref_rf[insn[24:20]];
  ii    = {{20{insn[31]}}, insn[31:20]};
  is    = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  ea    = a + ((insn[6:0] == rv_pkg::OP_STORE) ? is : ii);
  word  = ref_dmem[ea[11:2]] >> {ea[1:0], 3'b000};
  r     = '0;
  m     = '0;
  wr    = 1'b1;
  res   = 32'd0;
  taken = 1'b0;
  if (ref_halted) return;
  r.valid   = 1'b1;
  r.pc      = ref_pc;
  r.insn    = insn;
  r.rd      = insn[11:7];
  r.next_pc = ref_pc + 32'd4;
  case (insn[6:0])
    rv_pkg::OP_LUI:   res = {insn[31:12], 12'd0};
    rv_pkg::OP_AUIPC: res = ref_pc + {insn[31:12], 12'd0};
    rv_pkg::OP_JAL: begin
      res       = ref_pc + 32'd4;
      r.next_pc = ref_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    rv_pkg::OP_JALR: begin
      res       = ref_pc + 32'd4;
      r.next_pc = (a + ii) & ~32'd1;
    end
    rv_pkg::OP_BRANCH: begin
      wr = 1'b0;
      case (insn[14:12])
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        default: taken = a >= b;
      endcase
      if (taken) begin
        r.next_pc = ref_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      end
    end
    rv_pkg::OP_LOAD: begin
      m.ren  = 1'b1;
      m.addr = {ea[31:2], 2'b00};
      case (insn[14:12])
        3'd0: res = {{24{word[7]}}, word[7:0]};
        3'd1: res = {{16{word[15]}}, word[15:0]};
        3'd4: res = {24'd0, word[7:0]};
        3'd5: res = {16'd0, word[15:0]};
        default: res = word;
      endcase
    end
    rv_pkg::OP_STORE: begin
      wr     = 1'b0;
      m.wen  = 1'b1;
      m.addr = {ea[31:2], 2'b00};
      case (insn[13:12])
        2'd0: begin
          m.wmask = 4'b0001 << ea[1:0];
          m.wdata = {4{b[7:0]}};
        end
        2'd1: begin
          m.wmask = 4'b0011 << ea[1:0];
          m.wdata = {2{b[15:0]}};
        end
        default: begin
          m.wmask = 4'b1111;
          m.wdata = b;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (m.wmask[i]) ref_dmem[ea[11:2]][8*i +: 8] = m.wdata[8*i +: 8];
      end
    end
    rv_pkg::OP_IMM: res = ref_alu(insn[14:12], insn[14:12] == 3'd5 && insn[30], a, ii);
    rv_pkg::OP_REG: res = ref_alu(insn[14:12], insn[30], a, b);
    default: begin  // Only EBREAK is issued here
      wr         = 1'b0;
      ref_halted = insn == INSN_EBREAK;
    end
  endcase
  r.rd_wen   = wr;
  r.rd_wdata = res;
  if (wr && insn[11:7] != 5'd0) begin
    ref_rf[insn[11:7]] = res;
  end
  ref_pc = r.next_pc;
endfunction

`endif

/* tb/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

  localparam int CLK_PERIOD = 20;
  localparam int N_ALU      = 200;
  localparam int N_BRANCH   = 30;
  localparam int N_MEM      = 40;

  logic                clk = 1'b0;
  logic                rst = 1'b1;
  logic [31:0]         imem_addr;
  logic [31:0]         imem_data;
  rv_pkg::dmem_req_t   dmem_req;
  logic [31:0]         dmem_rdata;
  logic                halt;
  rv_pkg::retire_t     retire;

  logic [31:0] imem [1024];  // Program at IMEM_BASE
  logic [31:0] dmem [1024];  // Data at DMEM_BASE
  int          prog_len = 0;
  logic        prog_ready = 1'b0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          ebreak_retires = 0;

  `include "rv_ref_model.svh"

  rv_core #(.RESET_PC(IMEM_BASE)) u_dut (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .halt(halt), .retire(retire)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[11:2]];

  always @(posedge clk) begin
    if (dmem_req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.wmask[i]) begin
          dmem[dmem_req.addr[11:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ (addr >> 7);
  endfunction

  task automatic emit(input logic [31:0] insn);
    imem[10'(prog_len)] = insn;
    prog_len++;
  endtask

  task automatic add_alu_insn();
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    f3  = 3'($urandom % 8);
    alt = 1'($urandom % 2);
    rd  = 5'($urandom % 16);  // x0 included
    rs1 = 5'($urandom % 16);
    rs2 = 5'($urandom % 16);
    imm = 12'($urandom);
    if ($urandom % 2 == 0) begin
      if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
      emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
    end else begin
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;
      emit(enc_i(imm, rs1, f3, rd, rv_pkg::OP_IMM));
    end
  endtask

  // Taken branch skips the counter increment
  task automatic add_branch();
    logic [2:0] f3;
    logic [4:0] rs1, rs2;
    f3  = 3'($urandom % 6);
    rs1 = 5'($urandom % 16);
    rs2 = 5'($urandom % 16);
    if (f3 >= 3'd2) f3 = f3 + 3'd2;
    if ($urandom % 4 == 0) rs2 = rs1;
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit(enc_i(12'd1, 5'd16, 3'd0, 5'd16, rv_pkg::OP_IMM));
  endtask

  task automatic add_store();
    logic [1:0]  sz;
    logic [11:0] off;
    sz  = 2'($urandom % 3);
    off = 12'(($urandom % 64) * 4);
    if (sz == 2'd0) off[1:0] = 2'($urandom % 4);
    if (sz == 2'd1) off[1] = 1'($urandom % 2);
    emit(enc_s(off, 5'(1 + $urandom % 15), 5'd31, {1'b0, sz}));
  endtask

  task automatic add_load();
    logic [2:0]  f3;
    logic [11:0] off;
    f3  = 3'($urandom % 5);
    off = 12'(($urandom % 64) * 4);
    if (f3 >= 3'd3) f3 = f3 + 3'd1;  // LB LH LW LBU LHU
    if (f3[1:0] == 2'd0) off[1:0] = 2'($urandom % 4);
    if (f3[1:0] == 2'd1) off[1] = 1'($urandom % 2);
    emit(enc_i(off, 5'd31, f3, 5'(1 + $urandom % 15), rv_pkg::OP_LOAD));
  endtask

  task automatic build_program();
    logic [31:0] v, hi;
    foreach (imem[i]) begin
      imem[i] = INSN_EBREAK;
    end
    foreach (dmem[i]) begin
      dmem[i]     <= fill_word(DMEM_BASE + 32'(i) * 32'd4);
      ref_dmem[i] = fill_word(DMEM_BASE + 32'(i) * 32'd4);
    end
    emit(enc_u(DMEM_BASE[31:12], 5'd31, rv_pkg::OP_LUI));
    for (int r = 1; r < 17; r++) begin
      v  = $urandom;
      hi = v + 32'h800;  // Undo ADDI sign extension
      emit(enc_u(hi[31:12], 5'(r), rv_pkg::OP_LUI));
      emit(enc_i(v[11:0], 5'(r), 3'd0, 5'(r), rv_pkg::OP_IMM));
    end
    for (int i = 0; i < N_ALU; i++) begin
      add_alu_insn();
    end
    for (int i = 0; i < N_BRANCH; i++) begin
      add_branch();
    end
    emit(enc_j(21'd8, 5'd17));
    emit(enc_i(12'd1, 5'd16, 3'd0, 5'd16, rv_pkg::OP_IMM));
    emit(enc_u(20'd0, 5'd18, rv_pkg::OP_AUIPC));
    emit(enc_i(12'd17, 5'd18, 3'd0, 5'd18, rv_pkg::OP_IMM));  // Odd target, bit 0 cleared
    emit(enc_i(12'd0, 5'd18, 3'd0, 5'd19, rv_pkg::OP_JALR));
    emit(enc_i(12'd1, 5'd16, 3'd0, 5'd16, rv_pkg::OP_IMM));
    for (int i = 0; i < N_MEM; i++) begin
      add_store();
    end
    for (int i = 0; i < N_MEM; i++) begin
      add_load();
    end
    emit(INSN_EBREAK);
    emit(enc_s(12'd0, 5'd1, 5'd31, 3'd2));  // Store held back by halt
    prog_ready = 1'b1;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_cycle();
    rv_pkg::retire_t   er;
    rv_pkg::dmem_req_t em;
    compare_field("imem_addr", imem_addr, ref_pc);
    compare_field("halt", {31'd0, halt}, {31'd0, ref_halted});
    ref_step(imem[ref_pc[11:2]], er, em);
    compare_field("retire.valid", {31'd0, retire.valid}, {31'd0, er.valid});
    compare_field("dmem_req.ren", {31'd0, dmem_req.ren}, {31'd0, em.ren});
    compare_field("dmem_req.wen", {31'd0, dmem_req.wen}, {31'd0, em.wen});
    if (er.valid) begin
      compare_field("retire.pc", retire.pc, er.pc);
      compare_field("retire.insn", retire.insn, er.insn);
      compare_field("retire.rd_wen", {31'd0, retire.rd_wen}, {31'd0, er.rd_wen});
      compare_field("retire.rd", {27'd0, retire.rd}, {27'd0, er.rd});
      compare_field("retire.next_pc", retire.next_pc, er.next_pc);
      if (er.rd_wen) compare_field("retire.rd_wdata", retire.rd_wdata, er.rd_wdata);
    end
    if (em.ren || em.wen) compare_field("dmem_req.addr", dmem_req.addr, em.addr);
    if (em.wen) begin
      compare_field("dmem_req.wmask", {28'd0, dmem_req.wmask}, {28'd0, em.wmask});
      compare_field("dmem_req.wdata", dmem_req.wdata, em.wdata);
    end
    if (retire.valid && retire.insn == INSN_EBREAK) ebreak_retires++;
  endtask

  // Outputs sampled mid-cycle, well after the edge
  initial begin
    @(negedge rst);
    @(negedge clk);
    compare_field("imem_addr after reset", imem_addr, IMEM_BASE);
    compare_field("halt after reset", {31'd0, halt}, 32'd0);
    compare_field("dmem_req.ren after reset", {31'd0, dmem_req.ren}, 32'd0);
    compare_field("dmem_req.wen after reset", {31'd0, dmem_req.wen}, 32'd0);
    forever begin
      check_cycle();
      @(negedge clk);
    end
  end

  initial begin
    wait (prog_ready);
    #(CLK_PERIOD * (prog_len + 200));
    $display("Timeout: core did not halt within %0d cycles", prog_len + 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h7a2625e6));
    ref_reset();
    build_program();
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    wait (halt === 1'b1);
    repeat (20) @(posedge clk);  // Halt must hold
    if (ebreak_retires != 1) begin
      n_errors++;
      $display("EBREAK retired %0d times instead of once", ebreak_retires);
    end
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
tb/tb_core.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_core -f flist.f -o tb_core_sim \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
